// ==== hw/rv_op_pkg.sv ====
`default_nettype none

package rv_op_pkg;

    // execution unit an operation is steered to
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_sel_e;

    // RV32I integer functions handled by the ALU
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11
    } alu_fn_e;

    // RV32M multiply functions, low or high product word
    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHSU = 2'd2,
        MUL_MULHU  = 2'd3
    } mul_fn_e;

    // decoded operation with resolved operand values
    typedef struct packed {
        unit_sel_e   unit;
        // read as alu_fn_e or mul_fn_e depending on unit
        logic [3:0]  fn;
        logic        use_imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [4:0]  rd;
    } issue_op_t;

endpackage

`default_nettype wire

// ==== hw/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // tag width sets the reorder buffer size
    localparam int ROB_IDX_W = 4;
    localparam int ROB_DEPTH = 1 << ROB_IDX_W;

    typedef logic [ROB_IDX_W-1:0] rob_tag_t;

    // request into the single-cycle ALU
    typedef struct packed {
        rob_tag_t           tag;
        rv_op_pkg::alu_fn_e fn;
        logic [31:0]        a;
        logic [31:0]        b;
    } alu_req_t;

    // request into the multiplier pipeline
    typedef struct packed {
        rob_tag_t           tag;
        rv_op_pkg::mul_fn_e fn;
        logic [31:0]        a;
        logic [31:0]        b;
    } mul_req_t;

    // result written back into the reorder buffer
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] data;
    } unit_result_t;

    // one retired operation
    typedef struct packed {
        logic [31:0] order;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/op_queue.sv ====
`default_nettype none
`timescale 1ns/1ns

module op_queue #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count == '0);
    // a pop in the same cycle frees the slot for the push
    assign full_o  = (count == CNT_W'(DEPTH)) && !pop_i;
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && !full_o;
    assign data_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dispatch_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

module dispatch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_op_pkg::issue_op_t op_i,
    input  logic                 op_empty_i,
    output logic                 op_pop_o,
    input  logic                 rob_room_i,
    input  ooo_pkg::rob_tag_t    rob_tail_i,
    output logic                 alloc_o,
    output logic [4:0]           alloc_rd_o,
    output logic [31:0]          alloc_pc_o,
    output logic                 alu_req_valid_o,
    output ooo_pkg::alu_req_t    alu_req_o,
    output logic                 mul_req_valid_o,
    output ooo_pkg::mul_req_t    mul_req_o
);

    import rv_op_pkg::*;

    logic        pop;
    logic        is_mul;
    logic [31:0] opa;
    logic [31:0] opb;

    // issue only while the reorder buffer can take a new entry
    assign pop      = !op_empty_i && rob_room_i;
    assign op_pop_o = pop;
    assign is_mul   = (op_i.unit == UNIT_MUL);

    assign alloc_o    = pop;
    assign alloc_rd_o = op_i.rd;
    assign alloc_pc_o = op_i.pc;

    // auipc adds the immediate to the pc
    assign opa = (!is_mul && op_i.fn == ALU_AUIPC) ? op_i.pc : op_i.rs1_val;
    assign opb = op_i.use_imm ? op_i.imm : op_i.rs2_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_req_valid_o <= 1'b0;
            mul_req_valid_o <= 1'b0;
        end else begin
            alu_req_valid_o <= pop && !is_mul;
            mul_req_valid_o <= pop && is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !is_mul) begin
            alu_req_o <= '{tag: rob_tail_i, fn: alu_fn_e'(op_i.fn), a: opa, b: opb};
        end
        if (pop && is_mul) begin
            mul_req_o <= '{tag: rob_tail_i, fn: mul_fn_e'(op_i.fn[1:0]), a: opa, b: opb};
        end
    end

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  ooo_pkg::alu_req_t     req_i,
    output ooo_pkg::unit_result_t result_o
);

    import rv_op_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] alu_out;

    assign shamt = req_i.b[4:0];

    always_comb begin
        case (req_i.fn)
            ALU_ADD, ALU_AUIPC: alu_out = req_i.a + req_i.b;
            ALU_SUB:            alu_out = req_i.a - req_i.b;
            ALU_SLL:            alu_out = req_i.a << shamt;
            ALU_SLT:            alu_out = {31'b0, $signed(req_i.a) < $signed(req_i.b)};
            ALU_SLTU:           alu_out = {31'b0, req_i.a < req_i.b};
            ALU_XOR:            alu_out = req_i.a ^ req_i.b;
            ALU_SRL:            alu_out = req_i.a >> shamt;
            ALU_SRA:            alu_out = $unsigned($signed(req_i.a) >>> shamt);
            ALU_OR:             alu_out = req_i.a | req_i.b;
            ALU_AND:            alu_out = req_i.a & req_i.b;
            // immediate already shifted into place by decode
            ALU_LUI:            alu_out = req_i.b;
            default:            alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_o.valid <= 1'b0;
        end else begin
            result_o.valid <= req_valid_i;
        end
        result_o.tag  <= req_i.tag;
        result_o.data <= alu_out;
    end

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

module mul_unit #(
    parameter int STAGES = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  ooo_pkg::mul_req_t     req_i,
    output ooo_pkg::unit_result_t result_o
);

    import rv_op_pkg::*;
    import ooo_pkg::*;

    // one pipeline slot, word select is applied at the output
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic        hi;
        logic [63:0] prod;
    } stage_t;

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod_full;
    stage_t             pipe [STAGES];
    stage_t             last;

    // rs1 is signed for mulh and mulhsu, rs2 only for mulh
    assign a_ext     = {(req_i.fn != MUL_MULHU) & req_i.a[31], req_i.a};
    assign b_ext     = {(req_i.fn == MUL_MULH) & req_i.b[31], req_i.b};
    assign prod_full = a_ext * b_ext;

    always_ff @(posedge clk) begin
        pipe[0].tag  <= req_i.tag;
        pipe[0].hi   <= (req_i.fn != MUL_MUL);
        pipe[0].prod <= prod_full[63:0];
        for (int i = 1; i < STAGES; i++) begin
            pipe[i] <= pipe[i-1];
        end
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else begin
            pipe[0].valid <= req_valid_i;
        end
    end

    assign last = pipe[STAGES-1];

    assign result_o = '{
        valid: last.valid,
        tag:   last.tag,
        data:  last.hi ? last.prod[63:32] : last.prod[31:0]
    };

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`default_nettype none
`timescale 1ns/1ns

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_i,
    input  logic [4:0]            alloc_rd_i,
    input  logic [31:0]           alloc_pc_i,
    output logic                  room_o,
    output ooo_pkg::rob_tag_t     tail_o,
    input  ooo_pkg::unit_result_t alu_result_i,
    input  ooo_pkg::unit_result_t mul_result_i,
    input  logic                  commit_full_i,
    output logic                  commit_push_o,
    output ooo_pkg::commit_t      commit_o
);

    import ooo_pkg::*;

    logic [4:0]           rd_q   [ROB_DEPTH];
    logic [31:0]          pc_q   [ROB_DEPTH];
    logic [31:0]          data_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    rob_tag_t             head;
    rob_tag_t             tail;
    logic [ROB_IDX_W:0]   count;
    logic [31:0]          order;
    logic                 retire;

    // msb of count set means all entries in use
    assign room_o = !count[ROB_IDX_W];
    assign tail_o = tail;

    // head retires once its result is in and the retire queue has space
    assign retire        = (count != '0) && done_q[head] && !commit_full_i;
    assign commit_push_o = retire;

    assign commit_o = '{
        order: order,
        rd:    rd_q[head],
        data:  (rd_q[head] == 5'd0) ? 32'd0 : data_q[head],
        pc:    pc_q[head]
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            order  <= '0;
            done_q <= '0;
        end else begin
            if (alloc_i) begin
                tail         <= tail + 1'b1;
                done_q[tail] <= 1'b0;
            end
            // tags are unique, both units may write in one cycle
            if (alu_result_i.valid) begin
                done_q[alu_result_i.tag] <= 1'b1;
            end
            if (mul_result_i.valid) begin
                done_q[mul_result_i.tag] <= 1'b1;
            end
            if (retire) begin
                head  <= head + 1'b1;
                order <= order + 32'd1;
            end
            count <= count + (ROB_IDX_W + 1)'(alloc_i) - (ROB_IDX_W + 1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail] <= alloc_rd_i;
            pc_q[tail] <= alloc_pc_i;
        end
        if (alu_result_i.valid) begin
            data_q[alu_result_i.tag] <= alu_result_i.data;
        end
        if (mul_result_i.valid) begin
            data_q[mul_result_i.tag] <= mul_result_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exec_cluster.sv ====
`default_nettype none
`timescale 1ns/1ns

module exec_cluster #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MUL_STAGES  = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid_i,
    input  rv_op_pkg::issue_op_t issue_op_i,
    output logic                 issue_ready_o,
    output logic                 commit_valid_o,
    output ooo_pkg::commit_t     commit_o,
    input  logic                 commit_ready_i
);

    import rv_op_pkg::*;
    import ooo_pkg::*;

    issue_op_t    head_op;
    logic         issue_full;
    logic         issue_empty;
    logic         issue_pop;
    logic         rob_room;
    rob_tag_t     rob_tail;
    logic         alloc;
    logic [4:0]   alloc_rd;
    logic [31:0]  alloc_pc;
    logic         alu_req_valid;
    alu_req_t     alu_req;
    logic         mul_req_valid;
    mul_req_t     mul_req;
    unit_result_t alu_result;
    unit_result_t mul_result;
    logic         commit_full;
    logic         commit_push;
    logic         commit_empty;
    commit_t      rob_commit;

    assign issue_ready_o  = !issue_full;
    assign commit_valid_o = !commit_empty;

    op_queue #(.DEPTH(QUEUE_DEPTH), .payload_t(issue_op_t)) i_issue_q (
        .clk(clk), .rst(rst),
        .push_i(issue_valid_i), .data_i(issue_op_i), .full_o(issue_full),
        .pop_i(issue_pop), .data_o(head_op), .empty_o(issue_empty)
    );

    dispatch_unit i_dispatch (
        .clk(clk), .rst(rst),
        .op_i(head_op), .op_empty_i(issue_empty), .op_pop_o(issue_pop),
        .rob_room_i(rob_room), .rob_tail_i(rob_tail),
        .alloc_o(alloc), .alloc_rd_o(alloc_rd), .alloc_pc_o(alloc_pc),
        .alu_req_valid_o(alu_req_valid), .alu_req_o(alu_req),
        .mul_req_valid_o(mul_req_valid), .mul_req_o(mul_req)
    );

    alu_unit i_alu (
        .clk(clk), .rst(rst),
        .req_valid_i(alu_req_valid), .req_i(alu_req), .result_o(alu_result)
    );

    mul_unit #(.STAGES(MUL_STAGES)) i_mul (
        .clk(clk), .rst(rst),
        .req_valid_i(mul_req_valid), .req_i(mul_req), .result_o(mul_result)
    );

    reorder_buffer i_rob (
        .clk(clk), .rst(rst),
        .alloc_i(alloc), .alloc_rd_i(alloc_rd), .alloc_pc_i(alloc_pc),
        .room_o(rob_room), .tail_o(rob_tail),
        .alu_result_i(alu_result), .mul_result_i(mul_result),
        .commit_full_i(commit_full), .commit_push_o(commit_push), .commit_o(rob_commit)
    );

    op_queue #(.DEPTH(QUEUE_DEPTH), .payload_t(commit_t)) i_retire_q (
        .clk(clk), .rst(rst),
        .push_i(commit_push), .data_i(rob_commit), .full_o(commit_full),
        .pop_i(commit_ready_i), .data_o(commit_o), .empty_o(commit_empty)
    );

endmodule

`default_nettype wire

// ==== include/exec_ref.svh ====
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// expected ALU result, shifts use the low five bits of b
function automatic logic [31:0] ref_alu(rv_op_pkg::alu_fn_e fn, logic [31:0] a, logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (fn)
        rv_op_pkg::ALU_ADD:   return a + b;
        rv_op_pkg::ALU_AUIPC: return a + b;
        rv_op_pkg::ALU_SUB:   return a - b;
        rv_op_pkg::ALU_SLL:   return a << b[4:0];
        rv_op_pkg::ALU_SLT:   return (sa < $signed(b)) ? 32'd1 : 32'd0;
        rv_op_pkg::ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
        rv_op_pkg::ALU_XOR:   return a ^ b;
        rv_op_pkg::ALU_SRL:   return a >> b[4:0];
        rv_op_pkg::ALU_SRA:   return sa >>> b[4:0];
        rv_op_pkg::ALU_OR:    return a | b;
        rv_op_pkg::ALU_AND:   return a & b;
        rv_op_pkg::ALU_LUI:   return b;
        default:              return 32'd0;
    endcase
endfunction

// expected multiply word from 64-bit extended operands
function automatic logic [31:0] ref_mul(rv_op_pkg::mul_fn_e fn, logic [31:0] a, logic [31:0] b);
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] sa;
    logic [63:0] sb;
    ua = {32'b0, a};
    ub = {32'b0, b};
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    case (fn)
        rv_op_pkg::MUL_MUL:    return a * b;
        rv_op_pkg::MUL_MULH:   return 32'((sa * sb) >> 32);
        rv_op_pkg::MUL_MULHSU: return 32'((sa * ub) >> 32);
        default:               return 32'((ua * ub) >> 32);
    endcase
endfunction

// full commit record expected for one accepted operation
function automatic ooo_pkg::commit_t ref_commit(rv_op_pkg::issue_op_t op, logic [31:0] order);
    logic        is_mul;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    is_mul = (op.unit == rv_op_pkg::UNIT_MUL);
    a = (!is_mul && op.fn == rv_op_pkg::ALU_AUIPC) ? op.pc : op.rs1_val;
    b = op.use_imm ? op.imm : op.rs2_val;
    if (is_mul) begin
        data = ref_mul(rv_op_pkg::mul_fn_e'(op.fn[1:0]), a, b);
    end else begin
        data = ref_alu(rv_op_pkg::alu_fn_e'(op.fn), a, b);
    end
    if (op.rd == 5'd0) begin
        data = 32'd0;
    end
    return '{order: order, rd: op.rd, data: data, pc: op.pc};
endfunction

`endif

// ==== verif/tb_exec_cluster.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_exec_cluster;

    import rv_op_pkg::*;
    import ooo_pkg::*;

    `include "exec_ref.svh"

    localparam int TIMEOUT = 1000;
    localparam logic [31:0] CORNER [6] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                                            32'hffff_ffff, 32'h1234_5678};

    logic      clk;
    logic      rst;
    logic      issue_valid_i;
    issue_op_t issue_op_i;
    logic      issue_ready_o;
    logic      commit_valid_o;
    commit_t   commit_o;
    logic      commit_ready_i;

    integer      seed;
    logic        rand_ready;
    logic        timed_out;
    logic [31:0] next_pc;
    int          errors = 0;
    int          issued = 0;
    int          committed = 0;
    int          sb_count = 0;
    commit_t     exp_commit = '0;
    commit_t     sb [$];

    exec_cluster #(.QUEUE_DEPTH(4), .MUL_STAGES(3)) i_dut (
        .clk(clk), .rst(rst),
        .issue_valid_i(issue_valid_i), .issue_op_i(issue_op_i), .issue_ready_o(issue_ready_o),
        .commit_valid_o(commit_valid_o), .commit_o(commit_o), .commit_ready_i(commit_ready_i)
    );

    always #5 clk = ~clk;

    // scoreboard follows both handshakes
    // expected head is held for the next edge
    always @(posedge clk) begin
        if (!rst) begin
            if (issue_valid_i && issue_ready_o) begin
                sb.push_back(ref_commit(issue_op_i, 32'(issued)));
                issued++;
            end
            if (commit_valid_o && commit_ready_i) begin
                committed++;
                if (sb.size() > 0) begin
                    void'(sb.pop_front());
                end
            end
        end
        sb_count = sb.size();
        exp_commit = (sb.size() > 0) ? sb[0] : '0;
    end

    assert property (@(posedge clk) disable iff (rst)
        (commit_valid_o && commit_ready_i) |-> (sb_count > 0 && commit_o == exp_commit))
    else begin
        errors++;
        $display("error: %0t commit order %0d rd %0d data %h, expected order %0d rd %0d data %h",
                 $time, $sampled(commit_o.order), $sampled(commit_o.rd), $sampled(commit_o.data),
                 $sampled(exp_commit.order), $sampled(exp_commit.rd),
                 $sampled(exp_commit.data));
    end

    assert property (@(posedge clk) disable iff (rst)
        (commit_valid_o && !commit_ready_i) |=> (commit_valid_o && $stable(commit_o)))
    else begin
        errors++;
        $display("error: %0t commit_o changed or dropped before it was taken", $time);
    end

    // x0 never receives a value
    assert property (@(posedge clk) disable iff (rst)
        (commit_valid_o && commit_o.rd == 5'd0) |-> (commit_o.data == 32'd0))
    else begin
        errors++;
        $display("error: %0t rd zero committed data %h", $time, $sampled(commit_o.data));
    end

    function automatic issue_op_t make_op(unit_sel_e unit, logic [3:0] fn, logic use_imm,
                                          logic [31:0] a, logic [31:0] b, logic [31:0] imm,
                                          logic [4:0] rd);
        issue_op_t op;
        op = '{unit: unit, fn: fn, use_imm: use_imm, rs1_val: a, rs2_val: b, imm: imm,
               pc: 32'd0, rd: rd};
        return op;
    endfunction

    function automatic issue_op_t random_op();
        issue_op_t op;
        op = '0;
        op.unit = unit_sel_e'($random(seed) & 1);
        if (op.unit == UNIT_MUL) begin
            op.fn = 4'($random(seed) & 3);
        end else begin
            op.fn = 4'($unsigned($random(seed)) % 12);
        end
        op.use_imm = 1'($random(seed));
        op.rs1_val = $random(seed);
        op.rs2_val = ($random(seed) & 7) == 0 ? CORNER[$unsigned($random(seed)) % 6] : $random(seed);
        op.imm = $random(seed);
        op.rd = 5'($random(seed));
        return op;
    endfunction

    // every rising edge of the main sequence goes through here
    task automatic tick();
        @(posedge clk);
        if (rand_ready) begin
            commit_ready_i <= ($random(seed) & 3) != 0;
        end
    endtask

    task automatic drive_op(input issue_op_t op);
        op.pc = next_pc;
        next_pc = next_pc + 32'd4;
        issue_valid_i <= 1'b1;
        issue_op_i <= op;
    endtask

    task automatic wait_accept(input int limit, output logic ok);
        int waited;
        waited = 0;
        do begin
            tick();
            waited++;
        end while (!issue_ready_o && waited < limit);
        ok = issue_ready_o;
    endtask

    task automatic issue_op(input issue_op_t op);
        logic ok;
        if (timed_out) begin
            return;
        end
        drive_op(op);
        wait_accept(TIMEOUT, ok);
        if (!ok) begin
            $display("timeout: operation %0d was not accepted within %0d cycles", issued, TIMEOUT);
            timed_out = 1'b1;
        end
        issue_valid_i <= 1'b0;
    endtask

    task automatic drain_scoreboard();
        int waited;
        waited = 0;
        @(negedge clk);
        while (sb.size() != 0 && waited < TIMEOUT && !timed_out) begin
            tick();
            @(negedge clk);
            waited++;
        end
        if (sb.size() != 0 && !timed_out) begin
            $display("timeout: %0d operations never committed", sb.size());
            timed_out = 1'b1;
        end
        tick();
    endtask

    task automatic check_backpressure();
        logic ok;
        int   n;
        commit_ready_i <= 1'b0;
        ok = 1'b1;
        n = 0;
        // a stall of 30 cycles means every buffer is full
        while (ok && n < 40) begin
            drive_op(random_op());
            wait_accept(30, ok);
            n++;
        end
        assert (!ok) else begin
            errors++;
            $display("error: %0t issue_ready_o never dropped with commit_ready_i low", $time);
        end
        commit_ready_i <= 1'b1;
        if (!ok) begin
            wait_accept(TIMEOUT, ok);
            if (!ok) begin
                $display("timeout: stalled operation not accepted after release");
                timed_out = 1'b1;
            end
        end
        issue_valid_i <= 1'b0;
        drain_scoreboard();
    endtask

    initial begin
        seed = 32'h7501d0b0;
        clk = 1'b0;
        rst = 1'b1;
        issue_valid_i = 1'b0;
        issue_op_i = '0;
        commit_ready_i = 1'b1;
        rand_ready = 1'b0;
        timed_out = 1'b0;
        next_pc = 32'h0000_1000;

        tick();
        tick();
        rst <= 1'b0;
        tick();
        assert (!commit_valid_o && issue_ready_o) else begin
            errors++;
            $display("error: %0t wrong state after reset, commit_valid_o %b issue_ready_o %b",
                     $time, commit_valid_o, issue_ready_o);
        end

        for (int f = 0; f < 12; f++) begin
            for (int k = 0; k < 4; k++) begin
                issue_op(make_op(UNIT_ALU, 4'(f), k[0], CORNER[k], CORNER[k+2], CORNER[5-k],
                                 5'(k + 1)));
            end
        end
        drain_scoreboard();

        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) begin
                    issue_op(make_op(UNIT_MUL, 4'(f), 1'b0, CORNER[i], CORNER[j], 32'd0, 5'd7));
                end
            end
        end
        drain_scoreboard();

        // slow multiplies overtaken by younger ALU ops
        for (int n = 0; n < 8; n++) begin
            issue_op(make_op(UNIT_MUL, 4'(n % 4), 1'b0, $random(seed), $random(seed), 32'd0,
                             5'(n)));
            issue_op(make_op(UNIT_ALU, ALU_ADD, 1'b1, $random(seed), 32'd0, $random(seed),
                             5'(n % 2)));
            issue_op(make_op(UNIT_ALU, ALU_XOR, 1'b0, $random(seed), $random(seed), 32'd0,
                             5'(n + 8)));
        end
        drain_scoreboard();

        if (!timed_out) begin
            check_backpressure();
        end

        rand_ready = 1'b1;
        for (int n = 0; n < 300 && !timed_out; n++) begin
            issue_op(random_op());
        end
        drain_scoreboard();
        rand_ready = 1'b0;

        $display("issued %0d, committed %0d, pending %0d, errors %0d",
                 issued, committed, sb.size(), errors);
        if (errors == 0 && !timed_out && sb.size() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hw/rv_op_pkg.sv
hw/ooo_pkg.sv
hw/op_queue.sv
hw/dispatch_unit.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reorder_buffer.sv
hw/exec_cluster.sv
verif/tb_exec_cluster.sv
